// File: source/SlaveDaq_params.svh
`ifndef SLAVEDAQ_PARAMS_SVH
`define SLAVEDAQ_PARAMS_SVH

//////////////////////////////
// Chip timing in Clk cycles
//////////////////////////////

// ResetB low time after power-on
`define TIME_POWER_RESET 8

// Settling time before triggers are accepted
`define TIME_RESET_START 40

// Extra StartReadout cycles beyond the first
`define TIME_SRO 16

// Wait for the last data after run-enable drops
`define TIME_DRAIN 1600

//////////////////////////////
// Frame markers
//////////////////////////////

`define MARK_TRIG 8'hAA
`define MARK_COUNT 8'hCC
`define WORD_TAIL_HEAD 16'hFF45
`define WORD_TAIL_END 16'h45FF

`endif

// File: source/SlaveDaqPkg.sv
package SlaveDaqPkg;

	typedef logic [15:0] DaqWord;     // One word of the readout stream
	typedef logic [23:0] TrigCount;   // Triggers seen in one run
	typedef logic [15:0] DelayCount;  // Window and hold lengths in Clk cycles

	// Sequencer states
	// The order matters: power and count enables are decoded as ranges
	typedef enum logic [3:0] {
		Idle,
		ChipReset,
		PowerOn,
		Release,
		WaitStart,
		Acquire,
		WaitRead,
		StartRead,
		WaitReadDone,
		OnceEnd,
		EmitTrigId,
		Drain,
		EmitTail,
		AllDone
	} SeqState;

endpackage

// File: source/DaqEventSync.sv
`timescale 1ns/1ps

module DaqEventSync (
	input  logic Clk,
	input  logic reset_n,
	input  logic AcqStart,
	input  logic ChipSatB,
	input  logic EndReadout,
	output logic AcqTrig,
	output logic ChipFull,
	output logic ReadReady,
	output logic ReadEnd
);

	// Bit 0 AcqStart, bit 1 ChipSatB, bit 2 EndReadout
	localparam logic [2:0] IdleLevels = 3'b010;  // ChipSatB idles high

	logic [2:0] syncA;
	logic [2:0] syncB;
	logic [2:0] prevB;

	//////////////////////////////
	// Two-flop synchronisers
	//////////////////////////////
	always_ff @(posedge Clk or negedge reset_n) begin
		if (!reset_n) begin
			syncA <= IdleLevels;
			syncB <= IdleLevels;
			prevB <= IdleLevels;
		end else begin
			syncA <= {EndReadout, ChipSatB, AcqStart};
			syncB <= syncA;
			prevB <= syncB;  // Last synchronised level for edge detection
		end
	end

	//////////////////////////////
	// Registered edge pulses
	//////////////////////////////
	always_ff @(posedge Clk or negedge reset_n) begin
		if (!reset_n) begin
			AcqTrig   <= 1'b0;
			ChipFull  <= 1'b0;
			ReadReady <= 1'b0;
			ReadEnd   <= 1'b0;
		end else begin
			AcqTrig   <= syncB[0] & ~prevB[0];  // Trigger rising edge
			ChipFull  <= ~syncB[1] & prevB[1];  // Chip saturated
			ReadReady <= syncB[1] & ~prevB[1];  // Saturation released, readout may start
			ReadEnd   <= ~syncB[2] & prevB[2];  // End of readout
		end
	end

endmodule

// File: source/AcqSequencer.sv
`timescale 1ns/1ps
`include "SlaveDaq_params.svh"

module AcqSequencer (
	input  logic                   Clk,
	input  logic                   reset_n,
	input  logic                   ModuleStart,
	input  SlaveDaqPkg::DelayCount AcquisitionTime,
	input  SlaveDaqPkg::DelayCount EndHoldTime,
	input  logic                   AcqTrig,
	input  logic                   ChipFull,
	input  logic                   ReadReady,
	input  logic                   ReadEnd,
	input  logic                   Hit,
	input  logic                   EmitDone,
	input  logic                   DataTransmitDone,
	output logic                   ResetB,
	output logic                   StartAcq,
	output logic                   ForceExternalRaz,
	output logic                   StartReadout,
	output logic                   PwrOnA,
	output logic                   PwrOnD,
	output logic                   PwrOnDac,
	output logic                   OnceEnd,
	output logic                   AllDone,
	output logic                   CountClear,
	output logic                   CountEnable,
	output logic                   HitClear,
	output logic                   EmitTrigId,
	output logic                   EmitTail
);

	import SlaveDaqPkg::*;

	SeqState   state;
	DelayCount delayCnt;  // Shared by every timed state
	logic      holdDone;

	// State labels that share a name with a port are taken from the package by scope
	assign holdDone = (state == SlaveDaqPkg::OnceEnd) && (delayCnt >= EndHoldTime);

	//////////////////////////////
	// Pulses to the framer
	//////////////////////////////
	assign CountClear = (state == Idle) && ModuleStart;              // New run
	assign HitClear   = (state == WaitStart) && ModuleStart && AcqTrig;
	assign EmitTrigId = holdDone && Hit;                             // Only after data
	assign EmitTail   = (state == Drain) && (delayCnt >= DelayCount'(`TIME_DRAIN));
	assign CountEnable = state inside {[WaitStart : SlaveDaqPkg::EmitTrigId]};

	//////////////////////////////
	// State decoded outputs
	//////////////////////////////
	assign ForceExternalRaz = ~StartAcq;
	assign PwrOnA   = state inside {[ChipReset : SlaveDaqPkg::OnceEnd]};
	assign PwrOnDac = PwrOnA;   // DAC follows the analogue supply
	assign PwrOnD   = state inside {[PowerOn : SlaveDaqPkg::OnceEnd]};
	assign OnceEnd  = (state == SlaveDaqPkg::OnceEnd);
	assign AllDone  = (state == SlaveDaqPkg::AllDone);  // Held until the host acknowledges

	//////////////////////////////
	// Sequencer FSM
	//////////////////////////////
	always_ff @(posedge Clk or negedge reset_n) begin
		if (!reset_n) begin
			state        <= Idle;
			delayCnt     <= '0;
			ResetB       <= 1'b1;
			StartAcq     <= 1'b0;
			StartReadout <= 1'b0;
		end else begin
			case (state)
				Idle: begin
					if (ModuleStart) begin
						ResetB <= 1'b0;   // Hold the chip digital part in reset
						state  <= ChipReset;
					end
				end
				ChipReset: state <= PowerOn;
				PowerOn: begin
					if (delayCnt < DelayCount'(`TIME_POWER_RESET - 1)) begin
						delayCnt <= delayCnt + 1'b1;
					end else begin
						delayCnt <= '0;
						ResetB   <= 1'b1;
						state    <= Release;
					end
				end
				Release: begin
					if (delayCnt < DelayCount'(`TIME_RESET_START)) begin
						delayCnt <= delayCnt + 1'b1;
					end else begin
						delayCnt <= '0;
						state    <= WaitStart;
					end
				end
				WaitStart: begin
					if (!ModuleStart) begin
						state <= Drain;      // Run stopped by the host
					end else if (AcqTrig) begin
						StartAcq <= 1'b1;
						state    <= Acquire;
					end
				end
				Acquire: begin
					// Window closes on timeout or when the chip is full
					if (ChipFull || (delayCnt >= AcquisitionTime)) begin
						delayCnt <= '0;
						StartAcq <= 1'b0;
						state    <= WaitRead;
					end else begin
						delayCnt <= delayCnt + 1'b1;
					end
				end
				WaitRead: begin
					if (ReadReady) begin
						StartReadout <= 1'b1;
						state        <= StartRead;
					end
				end
				StartRead: begin
					if (delayCnt < DelayCount'(`TIME_SRO)) begin
						delayCnt <= delayCnt + 1'b1;
					end else begin
						delayCnt     <= '0;
						StartReadout <= 1'b0;
						state        <= WaitReadDone;
					end
				end
				WaitReadDone: if (ReadEnd) state <= SlaveDaqPkg::OnceEnd;
				SlaveDaqPkg::OnceEnd: begin
					if (holdDone) begin
						delayCnt <= '0;
						state    <= Hit ? SlaveDaqPkg::EmitTrigId : WaitStart;
					end else begin
						delayCnt <= delayCnt + 1'b1;
					end
				end
				SlaveDaqPkg::EmitTrigId: if (EmitDone) state <= WaitStart;
				Drain: begin
					if (EmitTail) begin
						delayCnt <= '0;
						state    <= SlaveDaqPkg::EmitTail;
					end else begin
						delayCnt <= delayCnt + 1'b1;
					end
				end
				SlaveDaqPkg::EmitTail: if (EmitDone) state <= SlaveDaqPkg::AllDone;
				SlaveDaqPkg::AllDone: if (DataTransmitDone) state <= Idle;
				default: state <= Idle;
			endcase
		end
	end

endmodule

// File: source/DaqFramer.sv
`timescale 1ns/1ps
`include "SlaveDaq_params.svh"

module DaqFramer (
	input  logic                Clk,
	input  logic                reset_n,
	input  logic                AcqTrig,
	input  logic                CountClear,
	input  logic                CountEnable,
	input  logic                HitClear,
	input  logic                EmitTrigId,
	input  logic                EmitTail,
	input  SlaveDaqPkg::DaqWord AsicData,
	input  logic                AsicDataValid,
	output SlaveDaqPkg::DaqWord DaqData,
	output logic                DaqDataValid,
	output logic                Hit,
	output logic                EmitDone
);

	import SlaveDaqPkg::*;

	TrigCount   count;
	DaqWord     insWord;
	logic       active;    // Inserting the words after the first
	logic       isTail;
	logic [1:0] wordIdx;
	logic       request;
	logic       sending;
	logic       curTail;
	logic [1:0] curIdx;
	logic       lastWord;
	logic       lastOut;   // Last word is on the output

	assign request  = EmitTrigId | EmitTail;
	assign sending  = request | active;
	assign curTail  = request ? EmitTail : isTail;
	assign curIdx   = request ? 2'd0 : wordIdx;  // First word goes out on the request edge
	assign lastWord = sending && (curIdx == (curTail ? 2'd3 : 2'd1));

	//////////////////////////////
	// Inserted word select
	//////////////////////////////
	always_comb begin
		if (curTail) begin
			case (curIdx)
				2'd0:    insWord = `WORD_TAIL_HEAD;
				2'd1:    insWord = {`MARK_COUNT, count[23:16]};
				2'd2:    insWord = count[15:0];
				default: insWord = `WORD_TAIL_END;
			endcase
		end else begin
			insWord = (curIdx == 2'd0) ? {`MARK_TRIG, count[23:16]} : count[15:0];
		end
	end

	always_ff @(posedge Clk or negedge reset_n) begin
		if (!reset_n) begin
			count        <= '0;
			Hit          <= 1'b0;
			active       <= 1'b0;
			isTail       <= 1'b0;
			wordIdx      <= '0;
			lastOut      <= 1'b0;
			EmitDone     <= 1'b0;
			DaqDataValid <= 1'b0;
		end else begin
			if (CountClear) count <= '0;
			else if (AcqTrig && CountEnable) count <= count + 1'b1;
			if (HitClear) Hit <= 1'b0;
			else if (AsicDataValid) Hit <= 1'b1;  // Any chip data in this acquisition
			lastOut      <= lastWord;
			EmitDone     <= lastOut;
			DaqDataValid <= sending | AsicDataValid;
			if (request) begin
				active  <= 1'b1;
				isTail  <= EmitTail;
				wordIdx <= 2'd1;
			end else if (active) begin
				wordIdx <= wordIdx + 1'b1;
				if (lastWord) active <= 1'b0;
			end
		end
	end

	// Stream register, ASIC data passes with one cycle of latency
	always_ff @(posedge Clk) DaqData <= sending ? insWord : AsicData;

endmodule

// File: source/SlaveDaqTop.sv
`timescale 1ns/1ps

module SlaveDaqTop (
	input  logic                   Clk,
	input  logic                   reset_n,
	input  logic                   ModuleStart,
	input  SlaveDaqPkg::DelayCount AcquisitionTime,
	input  SlaveDaqPkg::DelayCount EndHoldTime,
	output logic                   AllDone,
	input  logic                   DataTransmitDone,
	input  logic                   AcqStart,
	input  logic                   ChipSatB,
	input  logic                   EndReadout,
	input  SlaveDaqPkg::DaqWord    AsicData,
	input  logic                   AsicDataValid,
	output logic                   ResetB,
	output logic                   StartAcq,
	output logic                   ForceExternalRaz,
	output logic                   StartReadout,
	output logic                   PwrOnA,
	output logic                   PwrOnD,
	output logic                   PwrOnDac,
	output SlaveDaqPkg::DaqWord    DaqData,
	output logic                   DaqDataValid
);

	logic acqTrig, chipFull, readReady, readEnd;
	logic countClear, countEnable, hitClear, emitTrigId, emitTail;
	logic hit, emitDone;

	//////////////////////////////
	// Input sync, sequencer, framer
	//////////////////////////////
	DaqEventSync u_DaqEventSync (.Clk(Clk), .reset_n(reset_n), .AcqStart(AcqStart),
		.ChipSatB(ChipSatB), .EndReadout(EndReadout), .AcqTrig(acqTrig),
		.ChipFull(chipFull), .ReadReady(readReady), .ReadEnd(readEnd));

	AcqSequencer u_AcqSequencer (.Clk(Clk), .reset_n(reset_n), .ModuleStart(ModuleStart),
		.AcquisitionTime(AcquisitionTime), .EndHoldTime(EndHoldTime), .AcqTrig(acqTrig),
		.ChipFull(chipFull), .ReadReady(readReady), .ReadEnd(readEnd), .Hit(hit),
		.EmitDone(emitDone), .DataTransmitDone(DataTransmitDone), .ResetB(ResetB),
		.StartAcq(StartAcq), .ForceExternalRaz(ForceExternalRaz),
		.StartReadout(StartReadout), .PwrOnA(PwrOnA), .PwrOnD(PwrOnD), .PwrOnDac(PwrOnDac),
		.OnceEnd(), .AllDone(AllDone), .CountClear(countClear), .CountEnable(countEnable),
		.HitClear(hitClear), .EmitTrigId(emitTrigId), .EmitTail(emitTail));

	DaqFramer u_DaqFramer (.Clk(Clk), .reset_n(reset_n), .AcqTrig(acqTrig),
		.CountClear(countClear), .CountEnable(countEnable), .HitClear(hitClear),
		.EmitTrigId(emitTrigId), .EmitTail(emitTail), .AsicData(AsicData),
		.AsicDataValid(AsicDataValid), .DaqData(DaqData), .DaqDataValid(DaqDataValid),
		.Hit(hit), .EmitDone(emitDone));

endmodule

// File: tb/SlaveDaq_asserts.sv
`timescale 1ns/1ps

module SlaveDaq_asserts (
	input logic Clk,
	input logic reset_n,
	input logic StartAcq,
	input logic ForceExternalRaz,
	input logic StartReadout,
	input logic DaqDataValid,
	input logic AllDone,
	input logic DataTransmitDone
);

	// Window control to the chip is always complementary
	assert property (@(posedge Clk) disable iff (!reset_n) StartAcq != ForceExternalRaz)
		else $error("StartAcq and ForceExternalRaz are not opposite");

	// Done request holds until the host acknowledges
	assert property (@(posedge Clk) disable iff (!reset_n)
		AllDone && !DataTransmitDone |=> AllDone)
		else $error("AllDone dropped before DataTransmitDone");

	assert property (@(posedge Clk) disable iff (!reset_n) !(DaqDataValid && StartReadout))
		else $error("DaqDataValid high while StartReadout is high");  // Readout not begun yet

endmodule

// File: tb/tb_SlaveDaq.sv
`timescale 1ns/1ps
`include "SlaveDaq_params.svh"

module tb_SlaveDaq;

	import SlaveDaqPkg::*;

	localparam int    ClkPeriod = 10;
	localparam int    LcgSeed   = 21;
	localparam string StimFile  = "tb/daq_stim.txt";
	localparam int    HoldTime  = 6;   // EndHoldTime for every acquisition

	logic      Clk, reset_n, ModuleStart, DataTransmitDone, AllDone;
	logic      AcqStart, ChipSatB, EndReadout, AsicDataValid, DaqDataValid;
	logic      ResetB, StartAcq, ForceExternalRaz, StartReadout, PwrOnA, PwrOnD, PwrOnDac;
	DelayCount AcquisitionTime, EndHoldTime;
	DaqWord    AsicData, DaqData;

	logic [15:0] stim [0:79];   // Record count, then five fields per acquisition
	DaqWord      expQ[$];       // Words still expected on DaqData
	logic [31:0] lcgState = 32'(LcgSeed);
	int          errors = 0;
	int          checks = 0;
	int          watchLimit = 0;
	int          trigCnt = 0;
	int          cnt;

	SlaveDaqTop u_SlaveDaqTop (.*);

	bind SlaveDaqTop SlaveDaq_asserts u_asserts (.Clk, .reset_n, .StartAcq, .ForceExternalRaz,
		.StartReadout, .DaqDataValid, .AllDone, .DataTransmitDone);

	function automatic DaqWord nextRandom();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return lcgState[30:15];
	endfunction

	task automatic checkValue(string name, int got, int exp);
		checks++;
		assert (got == exp) else begin
			errors++;
			$display("FAILED at %0t ns: %s expected %0h, got %0h", $time, name, exp, got);
		end
	endtask

	task automatic waitCycles(int n);
		repeat (n) @(negedge Clk);
	endtask

	//////////////////////////////
	// One trigger, window and readout
	//////////////////////////////
	task automatic runAcquisition(int gap, int acqTime, int early, int words, int hit);
		int width;
		waitCycles(gap);
		AcquisitionTime = DelayCount'(acqTime);
		AcqStart = 1'b1;
		trigCnt++;
		for (width = 0; !StartAcq; width++) @(negedge Clk);
		checkValue("StartAcq delay", width, 4);   // Sync, edge detect, sequencer
		checkValue("PwrOnA/PwrOnD/PwrOnDac", {PwrOnA, PwrOnD, PwrOnDac}, 3'b111);
		AcqStart = 1'b0;
		if (early != 0) ChipSatB = 1'b0;          // Chip full inside the window
		for (width = 0; StartAcq; width++) @(negedge Clk);
		checkValue("StartAcq width", width, (early != 0 && acqTime > 3) ? 4 : acqTime + 1);
		ChipSatB = 1'b0;
		waitCycles(2);
		ChipSatB = 1'b1;   // Rising edge lets the readout start
		while (!StartReadout) @(negedge Clk);
		EndReadout = 1'b1;
		for (width = 0; StartReadout; width++) @(negedge Clk);
		checkValue("StartReadout width", width, `TIME_SRO + 1);
		repeat (words) begin
			AsicData      = nextRandom();
			AsicDataValid = 1'b1;
			expQ.push_back(AsicData);
			@(negedge Clk);
		end
		AsicDataValid = 1'b0;
		EndReadout    = 1'b0;
		if (hit != 0) begin
			expQ.push_back({`MARK_TRIG, 8'(trigCnt >> 16)});
			expQ.push_back(16'(trigCnt));
		end
		waitCycles(HoldTime + 8);
		while (expQ.size() > 0) @(negedge Clk);
		waitCycles(4);
	endtask

	initial begin
		Clk = 1'b0;
		forever #(ClkPeriod / 2) Clk = ~Clk;
	end

	// Output stream and power order checked on the falling edge
	always @(negedge Clk) begin
		assert (!PwrOnD || PwrOnA) else begin
			errors++;
			$display("PwrOnD is on while PwrOnA is off at %0t ns", $time);
		end
		if (reset_n && DaqDataValid) begin
			assert (expQ.size() > 0) else begin
				errors++;
				$display("DaqDataValid high at %0t ns with no word expected", $time);
			end
			if (expQ.size() > 0) checkValue("DaqData", DaqData, expQ.pop_front());
		end
	end

	initial begin
		reset_n          = 1'b0;
		ModuleStart      = 1'b0;
		DataTransmitDone = 1'b0;
		AcqStart         = 1'b0;
		ChipSatB         = 1'b1;
		EndReadout       = 1'b0;
		AsicData         = '0;
		AsicDataValid    = 1'b0;
		AcquisitionTime  = '0;
		EndHoldTime      = DelayCount'(HoldTime);
		$readmemh(StimFile, stim);
		for (int i = 0; i < stim[0]; i++)
			watchLimit += stim[5*i+1] + stim[5*i+2] + stim[5*i+4] + HoldTime + 100;
		watchLimit += `TIME_DRAIN + 200;
		repeat (4) @(negedge Clk);
		reset_n = 1'b1;
		@(negedge Clk);
		checkValue("ResetB", ResetB, 1);
		checkValue("ForceExternalRaz", ForceExternalRaz, 1);
		checkValue("StartAcq", StartAcq, 0);
		checkValue("StartReadout", StartReadout, 0);
		checkValue("PwrOnA/PwrOnD/PwrOnDac", {PwrOnA, PwrOnD, PwrOnDac}, 0);
		checkValue("AllDone", AllDone, 0);
		checkValue("DaqDataValid", DaqDataValid, 0);

		//////////////////////////////
		// Run start and power-up
		//////////////////////////////
		ModuleStart = 1'b1;
		while (ResetB) @(negedge Clk);
		for (cnt = 0; !ResetB; cnt++) @(negedge Clk);
		checkValue("ResetB low cycles", cnt, `TIME_POWER_RESET + 1);
		waitCycles(`TIME_RESET_START + 1);
		for (int i = 0; i < stim[0]; i++)
			runAcquisition(stim[5*i+1], stim[5*i+2], stim[5*i+3], stim[5*i+4], stim[5*i+5]);

		// Run stop, then the tail and the done handshake
		ModuleStart = 1'b0;
		expQ.push_back(`WORD_TAIL_HEAD);
		expQ.push_back({`MARK_COUNT, 8'(trigCnt >> 16)});
		expQ.push_back(16'(trigCnt));
		expQ.push_back(`WORD_TAIL_END);
		while (!AllDone) @(negedge Clk);
		checkValue("tail words left", expQ.size(), 0);
		waitCycles(3);
		checkValue("AllDone held", AllDone, 1);
		DataTransmitDone = 1'b1;
		while (AllDone) @(negedge Clk);
		DataTransmitDone = 1'b0;
		waitCycles(2);
		checkValue("AllDone", AllDone, 0);
		checkValue("PwrOnA/PwrOnD/PwrOnDac", {PwrOnA, PwrOnD, PwrOnDac}, 0);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	initial begin
		wait (watchLimit > 0);
		repeat (watchLimit) @(posedge Clk);
		$display("Timeout: the run did not end within %0d cycles", watchLimit);
		$display("Checks: %0d, errors: %0d", checks, errors + 1);
		$display("Finished with errors");
		$finish;
	end

endmodule

// File: tb/daq_stim.txt
// First value is the number of acquisitions, then one line per acquisition (hex):
// trigger gap, AcquisitionTime, early ChipSatB fall, ASIC words, expected hit flag
8
3 10 0 4 1
1 0 0 0 0
5 40 1 6 1
2 3 1 1 1
8 1 0 2 1
1 20 1 0 0
4 7 0 A 1
2 64 1 3 1

// File: project.f
+incdir+source
source/SlaveDaqPkg.sv
source/DaqEventSync.sv
source/AcqSequencer.sv
source/DaqFramer.sv
source/SlaveDaqTop.sv
tb/SlaveDaq_asserts.sv
tb/tb_SlaveDaq.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and decide the result from the simulation output
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal -j 0 -f project.f --top-module tb_SlaveDaq || exit 1
out=$(./obj_dir/Vtb_SlaveDaq)
echo "$out"
echo "$out" | grep -qx "Finished with no errors" && echo "PASS" || { echo "FAIL"; exit 1; }
